/* fir_bus_pkg.sv */
package fir_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // register bus widths
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [11:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // byte addresses of the register map
    localparam bus_addr_t addr_ap_ctrl   = 12'h000;
    localparam bus_addr_t addr_data_len  = 12'h010;
    localparam bus_addr_t addr_tap_count = 12'h014;
    // coefficient window, one word per tap up to 0xfc
    localparam bus_addr_t addr_coef_base = 12'h080;

    // ap_ctrl bit positions
    localparam int ap_start_bit = 0;
    localparam int ap_done_bit  = 1;
    localparam int ap_idle_bit  = 2;

    ////////////////////////////////////////////////////////////////////////////
    // coefficient access from the register slave
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic       we;
        logic [4:0] idx;
        bus_data_t  wdata;
    } coef_req_t;

endpackage

/* fir_dsp_pkg.sv */
package fir_dsp_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // datapath words
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] sample_t;
    typedef logic [31:0] coef_t;
    // accumulator wraps modulo 2^32
    typedef logic [31:0] acc_t;

    // tap or history index
    typedef logic [4:0] tap_idx_t;
    // tap count, 1 to 32
    typedef logic [5:0] tap_cnt_t;

    localparam int max_taps = 32;

    ////////////////////////////////////////////////////////////////////////////
    // run setup seen by the engine
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0] data_len;
        tap_cnt_t    tap_count;
    } fir_cfg_t;

    // one sample in flight at a time
    typedef enum logic [2:0] {
        eng_idle,
        eng_wait_sample,
        eng_mac,
        eng_drain,
        eng_output
    } engine_state_t;

endpackage

/* fir_axil_regs.sv */
`timescale 1ns/1ps

module fir_axil_regs
    import fir_bus_pkg::*;
    import fir_dsp_pkg::*;
(
    input  logic      axis_clk,
    input  logic      axis_rst_n,
    input  logic      awvalid,
    input  bus_addr_t awaddr,
    input  logic      wvalid,
    input  bus_data_t wdata,
    input  logic      arvalid,
    input  bus_addr_t araddr,
    input  logic      rready,
    output logic      awready,
    output logic      wready,
    output logic      arready,
    output logic      rvalid,
    output bus_data_t rdata,
    output coef_req_t coef_req,
    input  coef_t     coef_rdata,
    output fir_cfg_t  cfg,
    output logic      start,
    input  logic      done,
    input  logic      idle
);

    logic      wr_go;
    logic      wr_fire;
    logic      rd_go;
    logic      rd_busy;
    logic      done_ack;
    logic      wr_coef;
    logic      rd_coef;
    logic      ap_done_q;
    bus_addr_t rd_addr_q;
    bus_data_t rd_reg_q;
    bus_data_t reg_rdata;
    tap_cnt_t  tap_wr;

    ////////////////////////////////////////////////////////////////////////////
    // handshakes
    ////////////////////////////////////////////////////////////////////////////

    // a read in flight holds off writes so coefficient read data stays put
    assign rd_busy = arready | rvalid;
    assign wr_go   = awvalid & wvalid & ~awready & ~rd_busy;
    assign rd_go   = arvalid & ~rd_busy & ~awready & ~wr_go;
    assign wr_fire = awready & awvalid;

    assign wr_coef  = awaddr[11:7] == addr_coef_base[11:7];
    assign rd_coef  = rd_addr_q[11:7] == addr_coef_base[11:7];
    assign done_ack = rvalid & rready & (rd_addr_q == addr_ap_ctrl);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            rd_addr_q <= '0;
        end else begin
            awready <= wr_go;
            wready  <= wr_go;
            arready <= rd_go;
            if (rd_go) begin
                rd_addr_q <= araddr;
            end
            if (arready) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // setup and ap_ctrl registers
    ////////////////////////////////////////////////////////////////////////////

    // out of range tap counts are pulled into 1..32
    always_comb begin
        if (wdata > bus_data_t'(max_taps)) begin
            tap_wr = tap_cnt_t'(max_taps);
        end else if (wdata == '0) begin
            tap_wr = tap_cnt_t'(1);
        end else begin
            tap_wr = wdata[5:0];
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            cfg.data_len  <= '0;
            cfg.tap_count <= tap_cnt_t'(1);
            ap_done_q     <= 1'b0;
        end else begin
            if (wr_fire && idle) begin
                if (awaddr == addr_data_len) begin
                    cfg.data_len <= wdata;
                end
                if (awaddr == addr_tap_count) begin
                    cfg.tap_count <= tap_wr;
                end
            end
            // done wins over a clearing read on the same edge
            if (done) begin
                ap_done_q <= 1'b1;
            end else if (done_ack) begin
                ap_done_q <= 1'b0;
            end
        end
    end

    assign start = wr_fire & idle & (awaddr == addr_ap_ctrl) & wdata[ap_start_bit];

    ////////////////////////////////////////////////////////////////////////////
    // read data
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        reg_rdata = '0;
        case (rd_addr_q)
            addr_ap_ctrl: begin
                reg_rdata[ap_done_bit] = ap_done_q;
                reg_rdata[ap_idle_bit] = idle;
            end
            addr_data_len:  reg_rdata = cfg.data_len;
            addr_tap_count: reg_rdata = bus_data_t'(cfg.tap_count);
            default:        reg_rdata = '0;
        endcase
    end

    // register value frozen for the whole rvalid phase
    always_ff @(posedge axis_clk) begin
        if (arready) begin
            rd_reg_q <= reg_rdata;
        end
    end

    assign rdata = rd_coef ? coef_rdata : rd_reg_q;

    // write index during a write beat, otherwise the pending read index
    assign coef_req.we    = wr_fire & wr_coef & idle;
    assign coef_req.idx   = awready ? awaddr[6:2] : rd_addr_q[6:2];
    assign coef_req.wdata = wdata;

endmodule

/* fir_coef_ram.sv */
`timescale 1ns/1ps

module fir_coef_ram
    import fir_bus_pkg::*;
    import fir_dsp_pkg::*;
(
    input  logic      axis_clk,
    input  coef_req_t bus_req,
    output coef_t     bus_rdata,
    input  tap_idx_t  eng_idx,
    output coef_t     eng_rdata
);

    coef_t mem [max_taps];

    // one write port shared with the bus read port
    always_ff @(posedge axis_clk) begin
        if (bus_req.we) begin
            mem[bus_req.idx] <= bus_req.wdata;
        end
        bus_rdata <= mem[bus_req.idx];
    end

    // engine side, read only
    always_ff @(posedge axis_clk) begin
        eng_rdata <= mem[eng_idx];
    end

endmodule

/* fir_sample_buf.sv */
`timescale 1ns/1ps

module fir_sample_buf
    import fir_dsp_pkg::*;
(
    input  logic     axis_clk,
    input  logic     axis_rst_n,
    input  logic     clear,
    input  logic     push,
    input  sample_t  push_data,
    input  tap_idx_t offset,
    output sample_t  rdata
);

    sample_t  mem [max_taps];
    tap_idx_t wptr_q;
    tap_idx_t rd_ptr;

    // write pointer always points at the next free slot
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wptr_q <= '0;
        end else if (clear) begin
            wptr_q <= '0;
        end else if (push) begin
            wptr_q <= wptr_q + 5'd1;
        end
    end

    // history before a run reads back as zero
    always_ff @(posedge axis_clk) begin
        if (clear) begin
            for (int i = 0; i < max_taps; i++) begin
                mem[i] <= '0;
            end
        end else if (push) begin
            mem[wptr_q] <= push_data;
        end
    end

    // offset 0 is the newest sample, index wraps in 5 bits
    assign rd_ptr = wptr_q - offset - 5'd1;

    always_ff @(posedge axis_clk) begin
        rdata <= mem[rd_ptr];
    end

endmodule

/* fir_mac_engine.sv */
`timescale 1ns/1ps

module fir_mac_engine
    import fir_dsp_pkg::*;
(
    input  logic     axis_clk,
    input  logic     axis_rst_n,
    input  fir_cfg_t cfg,
    input  logic     start,
    output logic     done,
    output logic     idle,
    input  logic     ss_tvalid,
    input  sample_t  ss_tdata,
    input  logic     ss_tlast,
    output logic     ss_tready,
    input  logic     sm_tready,
    output logic     sm_tvalid,
    output acc_t     sm_tdata,
    output logic     sm_tlast,
    output logic     buf_clear,
    output logic     buf_push,
    output sample_t  buf_data,
    output tap_idx_t tap_idx,
    input  coef_t    coef_in,
    input  sample_t  sample_in
);

    engine_state_t state_q;
    engine_state_t state_d;
    tap_idx_t      tap_idx_q;
    logic          mac_vld_q;
    acc_t          acc_q;
    logic [31:0]   out_cnt_q;
    logic          ss_fire;
    logic          sm_fire;
    logic          last_tap;
    logic          last_out;

    assign idle      = state_q == eng_idle;
    assign ss_tready = state_q == eng_wait_sample;
    assign sm_tvalid = state_q == eng_output;
    assign ss_fire   = ss_tvalid & ss_tready;
    assign sm_fire   = sm_tvalid & sm_tready;

    assign last_tap = {1'b0, tap_idx_q} == cfg.tap_count - tap_cnt_t'(1);
    assign last_out = out_cnt_q == cfg.data_len - 32'd1;

    assign sm_tdata  = acc_q;
    assign sm_tlast  = sm_tvalid & last_out;
    assign done      = sm_fire & last_out;

    assign buf_clear = idle & start;
    assign buf_push  = ss_fire;
    assign buf_data  = ss_tdata;
    assign tap_idx   = tap_idx_q;

    ////////////////////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            eng_idle:        if (start) state_d = eng_wait_sample;
            eng_wait_sample: if (ss_fire) state_d = eng_mac;
            eng_mac:         if (last_tap) state_d = eng_drain;
            // last RAM read lands here
            eng_drain:       state_d = eng_output;
            eng_output: begin
                if (sm_fire) begin
                    state_d = last_out ? eng_idle : eng_wait_sample;
                end
            end
            default:         state_d = eng_idle;
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state_q   <= eng_idle;
            tap_idx_q <= '0;
            mac_vld_q <= 1'b0;
            out_cnt_q <= '0;
        end else begin
            state_q   <= state_d;
            // RAM data follows the index one cycle later
            mac_vld_q <= state_q == eng_mac;
            if (ss_fire) begin
                tap_idx_q <= '0;
            end else if (state_q == eng_mac) begin
                tap_idx_q <= tap_idx_q + 5'd1;
            end
            if (buf_clear) begin
                out_cnt_q <= '0;
            end else if (sm_fire) begin
                out_cnt_q <= out_cnt_q + 32'd1;
            end
        end
    end

    // product kept to 32 bits, sum wraps
    always_ff @(posedge axis_clk) begin
        if (ss_fire) begin
            acc_q <= '0;
        end else if (mac_vld_q) begin
            acc_q <= acc_q + coef_in * sample_in;
        end
    end

endmodule

/* fir_top.sv */
`timescale 1ns/1ps

module fir_top
    import fir_bus_pkg::*;
    import fir_dsp_pkg::*;
(
    input  logic      awvalid,
    output logic      awready,
    input  bus_addr_t awaddr,
    input  logic      wvalid,
    output logic      wready,
    input  bus_data_t wdata,
    input  logic      arvalid,
    output logic      arready,
    input  bus_addr_t araddr,
    output logic      rvalid,
    input  logic      rready,
    output bus_data_t rdata,
    input  logic      ss_tvalid,
    input  sample_t   ss_tdata,
    input  logic      ss_tlast,
    output logic      ss_tready,
    output logic      sm_tvalid,
    output acc_t      sm_tdata,
    output logic      sm_tlast,
    input  logic      sm_tready,
    input  logic      axis_clk,
    input  logic      axis_rst_n
);

    coef_req_t coef_req;
    coef_t     coef_bus_rdata;
    coef_t     coef_eng_rdata;
    fir_cfg_t  cfg;
    logic      start;
    logic      done;
    logic      idle;
    logic      buf_clear;
    logic      buf_push;
    sample_t   buf_data;
    sample_t   buf_rdata;
    tap_idx_t  tap_idx;

    fir_axil_regs fir_axil_regs_inst (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .rready     (rready),
        .awready    (awready),
        .wready     (wready),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .coef_req   (coef_req),
        .coef_rdata (coef_bus_rdata),
        .cfg        (cfg),
        .start      (start),
        .done       (done),
        .idle       (idle)
    );

    fir_coef_ram fir_coef_ram_inst (
        .axis_clk  (axis_clk),
        .bus_req   (coef_req),
        .bus_rdata (coef_bus_rdata),
        .eng_idx   (tap_idx),
        .eng_rdata (coef_eng_rdata)
    );

    // same index walks both memories
    fir_sample_buf fir_sample_buf_inst (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .clear      (buf_clear),
        .push       (buf_push),
        .push_data  (buf_data),
        .offset     (tap_idx),
        .rdata      (buf_rdata)
    );

    fir_mac_engine fir_mac_engine_inst (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .cfg        (cfg),
        .start      (start),
        .done       (done),
        .idle       (idle),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .buf_clear  (buf_clear),
        .buf_push   (buf_push),
        .buf_data   (buf_data),
        .tap_idx    (tap_idx),
        .coef_in    (coef_eng_rdata),
        .sample_in  (buf_rdata)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic axis_clk,
    output logic axis_rst_n
);

    // 40 ns period
    localparam int half_period_ns = 20;

    initial begin
        axis_clk = 1'b0;
        forever #(half_period_ns) axis_clk = ~axis_clk;
    end

    // reset low for the first 3 rising edges
    initial begin
        axis_rst_n = 1'b0;
        repeat (3) @(posedge axis_clk);
        axis_rst_n <= 1'b1;
    end

endmodule

/* fir_props.sv */
`timescale 1ns/1ps

module fir_props
    import fir_bus_pkg::*;
    import fir_dsp_pkg::*;
(
    input logic      axis_clk,
    input logic      axis_rst_n,
    input logic      awready,
    input logic      wready,
    input logic      arready,
    input logic      rvalid,
    input logic      rready,
    input bus_data_t rdata,
    input logic      ss_tready,
    input logic      sm_tvalid,
    input logic      sm_tready,
    input acc_t      sm_tdata,
    input logic      sm_tlast
);

    int unsigned fail_count = 0;

    ////////////////////////////////////////////////////////////////////////////
    // reset state
    ////////////////////////////////////////////////////////////////////////////

    reset_quiet: assert property (@(posedge axis_clk)
        (!axis_rst_n || $rose(axis_rst_n)) |->
        !(awready || wready || arready || rvalid || ss_tready || sm_tvalid || sm_tlast))
    else begin
        fail_count++;
        $error("control output high during or right after reset");
    end

    ////////////////////////////////////////////////////////////////////////////
    // write channel
    ////////////////////////////////////////////////////////////////////////////

    aw_w_pair: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        awready == wready)
    else begin
        fail_count++;
        $error("awready and wready differ");
    end

    // single cycle pulse
    aw_pulse: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        awready |=> !awready)
    else begin
        fail_count++;
        $error("awready held longer than one cycle");
    end

    ////////////////////////////////////////////////////////////////////////////
    // hold under back-pressure
    ////////////////////////////////////////////////////////////////////////////

    rd_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
        fail_count++;
        $error("read data dropped or changed before rready");
    end

    sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
    else begin
        fail_count++;
        $error("stream output dropped or changed before sm_tready");
    end

endmodule

bind fir_top fir_props fir_props_inst (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .awready    (awready),
    .wready     (wready),
    .arready    (arready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast)
);

/* fir_tb.sv */
`timescale 1ns/1ps

module fir_tb
    import fir_bus_pkg::*;
    import fir_dsp_pkg::*;
();

    localparam int run1_taps      = 11;
    localparam int run1_len       = 40;
    localparam int run2_taps      = 32;
    localparam int run2_len       = 48;
    localparam int total_samples  = run1_len + run2_len;
    localparam int timeout_cycles = 4 * (total_samples * 34 + 200);

    logic        axis_clk;
    logic        axis_rst_n;
    logic        awvalid;
    logic        awready;
    bus_addr_t   awaddr;
    logic        wvalid;
    logic        wready;
    bus_data_t   wdata;
    logic        arvalid;
    logic        arready;
    bus_addr_t   araddr;
    logic        rvalid;
    logic        rready;
    bus_data_t   rdata;
    logic        ss_tvalid;
    sample_t     ss_tdata;
    logic        ss_tlast;
    logic        ss_tready;
    logic        sm_tvalid;
    acc_t        sm_tdata;
    logic        sm_tlast;
    logic        sm_tready;
    int          seed = 32'hc0a5;
    int unsigned tb_errors = 0;
    int unsigned prop_errors;
    int unsigned cycle_cnt = 0;
    coef_t       coef_model [max_taps];
    // newest sample at the front
    sample_t     hist [$];
    acc_t        exp_q [$];

    tb_clock_gen clock_gen_inst (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n)
    );

    fir_top fir_top_inst (
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .sm_tready  (sm_tready),
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n)
    );

    ////////////////////////////////////////////////////////////////////////////
    // checking and reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            tb_errors++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // y(n) = sum of h(k) * x(n-k), samples before the run are zero
    function automatic acc_t conv_model(input int taps);
        acc_t sum;
        sum = '0;
        for (int k = 0; k < taps; k++) begin
            if (k < hist.size()) begin
                sum = sum + coef_model[k] * hist[k];
            end
        end
        return sum;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // register bus
    ////////////////////////////////////////////////////////////////////////////

    task automatic write_reg(input bus_addr_t addr, input bus_data_t data);
        @(posedge axis_clk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr;
        wdata   <= data;
        @(negedge axis_clk);
        while (!(awready && wready)) begin
            @(negedge axis_clk);
        end
        @(posedge axis_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic read_reg(input bus_addr_t addr, output bus_data_t data);
        int hold;
        hold = $random(seed) & 3;
        @(posedge axis_clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        @(negedge axis_clk);
        while (!arready) begin
            @(negedge axis_clk);
        end
        @(posedge axis_clk);
        arvalid <= 1'b0;
        @(negedge axis_clk);
        while (!rvalid) begin
            @(negedge axis_clk);
        end
        // rready late so rdata has to hold
        repeat (hold) @(posedge axis_clk);
        @(posedge axis_clk);
        rready <= 1'b1;
        @(negedge axis_clk);
        data = rdata;
        @(posedge axis_clk);
        rready <= 1'b0;
    endtask

    task automatic load_coefs();
        bus_data_t rd;
        for (int i = 0; i < max_taps; i++) begin
            coef_model[i] = $random(seed);
            write_reg(addr_coef_base + bus_addr_t'(4 * i), coef_model[i]);
        end
        for (int i = 0; i < max_taps; i++) begin
            read_reg(addr_coef_base + bus_addr_t'(4 * i), rd);
            check_word($sformatf("coef[%0d]", i), rd, coef_model[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // streams
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_samples(input int taps, input int len);
        sample_t x;
        for (int i = 0; i < len; i++) begin
            x = $random(seed);
            @(posedge axis_clk);
            ss_tvalid <= 1'b1;
            ss_tdata  <= x;
            ss_tlast  <= (i == len - 1);
            @(negedge axis_clk);
            while (!ss_tready) begin
                @(negedge axis_clk);
            end
            hist.push_front(x);
            exp_q.push_back(conv_model(taps));
        end
        @(posedge axis_clk);
        ss_tvalid <= 1'b0;
        ss_tlast  <= 1'b0;
    endtask

    task automatic collect_outputs(input int len, input logic stall);
        int   count;
        acc_t exp_y;
        count = 0;
        while (count < len) begin
            @(posedge axis_clk);
            sm_tready <= stall ? (($random(seed) & 1) != 0) : 1'b1;
            @(negedge axis_clk);
            if (sm_tvalid && sm_tready) begin
                count++;
                if (exp_q.size() == 0) begin
                    tb_errors++;
                    $display("output %0d arrived with no sample behind it", count);
                end else begin
                    exp_y = exp_q.pop_front();
                    check_word("sm_tdata", sm_tdata, exp_y);
                end
                check_word("sm_tlast", 32'(sm_tlast), 32'(count == len));
            end
        end
        @(posedge axis_clk);
        sm_tready <= 1'b0;
    endtask

    task automatic run_filter(input int taps, input int len, input logic stall);
        bus_data_t rd;
        write_reg(addr_tap_count, bus_data_t'(taps));
        write_reg(addr_data_len, bus_data_t'(len));
        read_reg(addr_tap_count, rd);
        check_word("tap_count", rd, bus_data_t'(taps));
        read_reg(addr_data_len, rd);
        check_word("data_len", rd, bus_data_t'(len));
        hist.delete();
        exp_q.delete();
        write_reg(addr_ap_ctrl, bus_data_t'(1) << ap_start_bit);
        fork
            send_samples(taps, len);
            collect_outputs(len, stall);
        join
        if (exp_q.size() != 0) begin
            tb_errors++;
            $display("%0d expected outputs never arrived", exp_q.size());
        end
        // done and idle, then the first read clears done
        read_reg(addr_ap_ctrl, rd);
        check_word("ap_ctrl", rd, 32'h6);
        read_reg(addr_ap_ctrl, rd);
        check_word("ap_ctrl", rd, 32'h4);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        bus_data_t rd;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        ss_tvalid = 1'b0;
        ss_tdata  = '0;
        ss_tlast  = 1'b0;
        sm_tready = 1'b0;
        wait (axis_rst_n === 1'b1);
        @(negedge axis_clk);
        check_word("control outputs",
                   32'({awready, wready, arready, rvalid, ss_tready, sm_tvalid, sm_tlast}),
                   32'h0);
        read_reg(addr_ap_ctrl, rd);
        check_word("ap_ctrl", rd, 32'h4);
        load_coefs();
        run_filter(run1_taps, run1_len, 1'b0);
        // second run with fresh coefficients and sink stalls
        load_coefs();
        run_filter(run2_taps, run2_len, 1'b1);
        prop_errors = fir_top_inst.fir_props_inst.fail_count;
        $display("errors: %0d testbench, %0d protocol", tb_errors, prop_errors);
        if (tb_errors == 0 && prop_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        while (cycle_cnt < timeout_cycles) begin
            @(posedge axis_clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* vlog.f */
fir_bus_pkg.sv
fir_dsp_pkg.sv
fir_axil_regs.sv
fir_coef_ram.sv
fir_sample_buf.sv
fir_mac_engine.sv
fir_top.sv
tb_clock_gen.sv
fir_props.sv
fir_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module fir_tb -f vlog.f -o fir_sim

./obj_dir/fir_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
